/* Makefile */
# Verilator build and run of the ordering block testbench

TOP = sn_order_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only -Wall --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
verilog/sn_geom_pkg.sv
verilog/sn_mode_pkg.sv
verilog/sn_mode_cfg.sv
verilog/sn_shift_table.sv
verilog/sn_cmp_pipe.sv
verilog/sn_state_window.sv
verilog/sn_replay_select.sv
verilog/sn_order_top.sv
dv/sn_order_tb.sv

/* dv/sn_order_tb.sv */
// testbench for sn_order_top; random and directed completions and replay picks against a model
`timescale 1ns/1ns

module sn_order_tb;

  // numbers per slot in each run are multiples of 4
  localparam int IN_CNT  = 72;   // one slot past one mode 0 window
  localparam int MIX_CNT = 40;   // eight slots
  localparam int M1_CNT  = 132;
  localparam int M2_CNT  = 260;
  localparam int M3_CNT  = 520;
  localparam int TOTAL   = IN_CNT + 8 * MIX_CNT + 4 * M1_CNT + 2 * M2_CNT + M3_CNT + 16;
  localparam int MAX_CYC = 10 * TOTAL + 1000;  // about 4 cycles per number with margin

  logic                          clk;
  logic                          rst_n;
  logic                          cmp_v;
  logic [sn_geom_pkg::SN_W-1:0]  cmp_sn;
  logic [sn_geom_pkg::SLT_W-1:0] cmp_slt;
  logic                          cmp_ready;
  logic                          replay_v;
  logic                          replay_selected;
  logic                          replay_sequence_v;
  logic [sn_geom_pkg::SN_W-1:0]  replay_sequence;
  sn_mode_pkg::sn_mode_t         sn_mode;
  logic                          dup_err;

  // reference model
  int         seed = 9868;
  int         cyc = 0;
  int         head [8] = '{default: 0};  // expected shift per slot
  int         done_at [512];             // cycle the number shows in the state or -1
  int         last_w = 7;                // last replay winner
  int         pend_cnt = 0;              // completed but not yet replayed
  int         wlog = 6;                  // log2 of the window size
  int         h;
  string      test_name = "reset";
  logic [8:0] exp_seq = '0;
  logic       dup_drv = 1'b0;
  logic [2:0] dup_pipe = '0;             // p1, p2, state

  sn_order_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc      <= cyc + 1;
    dup_pipe <= {dup_pipe[1:0], dup_drv};
    if (cyc >= MAX_CYC) begin
      report_failure($sformatf("timeout: run still going after %0d cycles in %s",
                               cyc, test_name));
    end
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  function automatic int base_of(input int s);
    return s << wlog;
  endfunction

  function automatic int mask_of();
    return (1 << wlog) - 1;
  endfunction

  function automatic bit slot_ready(input int s);
    int idx;
    if (s >= (512 >> wlog)) return 1'b0;  // slot not in this mode
    idx = base_of(s) + (head[s] & mask_of());
    return (done_at[idx] >= 0) && (cyc >= done_at[idx]);
  endfunction

  function automatic bit any_ready();
    bit r;
    r = 1'b0;
    for (int s = 0; s < 8; s++) r |= slot_ready(s);
    return r;
  endfunction

  //--------------------------------------------------------------------
  // checks the offer and maybe picks and sends on one falling edge
  //--------------------------------------------------------------------

  task automatic step(input bit pick, input bit has_cmp, input int slt, input int sn,
                      output bit sent);
    int idx;
    int w;
    bit found;
    @(negedge clk);
    replay_selected = 1'b0;
    cmp_v           = 1'b0;
    dup_drv         = 1'b0;
    sent            = 1'b0;
    found           = 1'b0;
    w               = last_w;
    if (!replay_sequence_v) begin  // no offer in the advance cycle
      assert (replay_v == any_ready())
        else report_failure($sformatf("[FAIL] %s replay_v: expected %0b, actual %0b",
                                      test_name, any_ready(), replay_v));
    end
    if (pick && replay_v) begin
      for (int j = 1; j <= 8; j++) begin  // round robin from one past the last winner
        if (!found && slot_ready((last_w + j) % 8)) begin
          w     = (last_w + j) % 8;
          found = 1'b1;
        end
      end
      replay_selected  = 1'b1;
      exp_seq          = 9'(base_of(w) + (head[w] & mask_of()));
      done_at[exp_seq] = -1;
      pend_cnt--;
      head[w] = (head[w] + 1) & mask_of();  // wraps at the window size
      last_w  = w;
    end
    if (has_cmp && cmp_ready) begin
      idx     = base_of(slt) + (sn & mask_of());
      cmp_v   = 1'b1;
      cmp_sn  = 9'(sn);
      cmp_slt = 3'(slt);
      dup_drv = (done_at[idx] >= 0);  // still pending means a repeat
      if (!dup_drv) begin
        done_at[idx] = cyc + 3;
        pend_cnt++;
      end
      sent = 1'b1;
    end
  endtask

  task automatic send_one(input int slt, input int off);
    bit sent;
    sent = 1'b0;
    while (!sent) step(1'b0, 1'b1, slt, base_of(slt) + (off & mask_of()), sent);
  endtask

  task automatic idle(input int n);
    bit sent;
    repeat (n) step(1'b0, 1'b0, 0, 0, sent);
  endtask

  task automatic drain();
    bit sent;
    while (pend_cnt > 0) step(1'b1, 1'b0, 0, 0, sent);
    idle(4);  // let the last shift land
  endtask

  task automatic set_mode(input int m);
    sn_mode = sn_mode_pkg::sn_mode_t'(2'(m));
    wlog    = 6 + m;
    idle(2);
  endtask

  // blocks of 4 numbers per slot in turn and shuffled when mix is set
  task automatic run_stream(input int nslt, input int per_slt, input bit mix);
    int q[$];
    int nxt[8];
    int blk[4];
    int left;
    int s;
    int k;
    int tmp;
    int pk;
    bit sent;
    left = nslt * per_slt;
    s    = 0;
    for (int i = 0; i < 8; i++) nxt[i] = head[i];
    while (left > 0 || q.size() > 0) begin
      if (q.size() == 0 && left > 0 && pend_cnt < 16) begin
        for (int j = 0; j < 4; j++) begin
          blk[j] = (s << 9) | (base_of(s) + ((nxt[s] + j) & mask_of()));
        end
        for (int j = 3; j > 0; j--) begin
          k = mix ? int'($unsigned($random(seed)) % (j + 1)) : j;
          tmp    = blk[j];
          blk[j] = blk[k];
          blk[k] = tmp;
        end
        for (int j = 0; j < 4; j++) q.push_back(blk[j]);
        nxt[s] += 4;
        left   -= 4;
        s       = (s + 1) % nslt;
      end
      pk = (q.size() > 0) ? q[0] : 0;
      step(($random(seed) & 3) != 0, (q.size() > 0) && (($random(seed) & 1) != 0),
           pk >> 9, pk & 511, sent);
      if (sent) void'(q.pop_front());
    end
    drain();
  endtask

  //--------------------------------------------------------------------
  // checks on every edge
  //--------------------------------------------------------------------

  assert property (@(posedge clk) disable iff (!rst_n)
    replay_selected |=> (replay_sequence_v && (replay_sequence == exp_seq)))
    else report_failure($sformatf(
      "[FAIL] %s replay_sequence: expected %0d, actual %0d (v=%0b)",
      test_name, $sampled(exp_seq), $sampled(replay_sequence), $sampled(replay_sequence_v)));

  assert property (@(posedge clk) disable iff (!rst_n)
    !replay_selected |=> !replay_sequence_v)
    else report_failure($sformatf("[FAIL] %s replay_sequence_v: expected 0, actual 1",
      test_name));

  // advance cycle blocks both the offer and completions
  assert property (@(posedge clk) disable iff (!rst_n)
    replay_sequence_v |-> (!replay_v && !cmp_ready))
    else report_failure($sformatf(
      "[FAIL] %s advance cycle replay_v,cmp_ready: expected 00, actual %0b%0b",
      test_name, $sampled(replay_v), $sampled(cmp_ready)));

  // any other cycle takes a completion
  assert property (@(posedge clk) disable iff (!rst_n)
    !replay_sequence_v |-> cmp_ready)
    else report_failure($sformatf("[FAIL] %s cmp_ready: expected 1, actual 0", test_name));

  assert property (@(posedge clk) disable iff (!rst_n)
    dup_err == dup_pipe[2])
    else report_failure($sformatf("[FAIL] %s dup_err: expected %0b, actual %0b",
      test_name, $sampled(dup_pipe[2]), $sampled(dup_err)));

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------

  initial begin
    rst_n           = 1'b0;
    cmp_v           = 1'b0;
    cmp_sn          = '0;
    cmp_slt         = '0;
    replay_selected = 1'b0;
    sn_mode         = sn_mode_pkg::SN_QID_64;
    for (int i = 0; i < 512; i++) done_at[i] = -1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!replay_v && !replay_sequence_v && !dup_err && cmp_ready)
      else report_failure($sformatf(
        "[FAIL] %s replay_v,seq_v,dup_err,cmp_ready: %s, actual %b%b%b%b",
        test_name, "expected 0001", replay_v, replay_sequence_v, dup_err, cmp_ready));
    test_name = "in_order";
    run_stream(1, IN_CNT, 1'b0);
    test_name = "out_of_order";
    run_stream(8, MIX_CNT, 1'b1);
    test_name = "alternate";  // two slots ready at once
    for (int i = 0; i < 4; i++) begin
      send_one(0, head[0] + i);
      send_one(5, head[5] + i);
    end
    idle(4);
    drain();
    test_name = "duplicate";
    h = head[2];
    send_one(2, h + 1);
    idle(4);
    send_one(2, h + 1);  // head still missing so h + 1 is pending
    idle(4);
    send_one(2, h + 2);
    send_one(2, h);
    drain();
    test_name = "mode_128";
    set_mode(1);
    run_stream(4, M1_CNT, 1'b1);
    test_name = "mode_256";
    set_mode(2);
    run_stream(2, M2_CNT, 1'b1);
    test_name = "mode_512";
    set_mode(3);
    run_stream(1, M3_CNT, 1'b1);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* verilog/sn_cmp_pipe.sv */
// two-stage completion pipe; turns a completion number into a one-hot bit of the state vector
`timescale 1ns/1ns

module sn_cmp_pipe (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmp_v,
  input  logic [sn_geom_pkg::SN_W-1:0]   cmp_sn,
  input  logic [sn_geom_pkg::SLT_W-1:0]  cmp_slt,
  output logic                           cmp_ready,
  input  logic                           advance,
  input  logic [sn_geom_pkg::SLT_W-1:0]  advance_slt,
  output logic [sn_geom_pkg::SLT_W-1:0]  rd_slt,
  input  logic [sn_geom_pkg::SN_W-1:0]   rd_shift,
  input  sn_mode_pkg::sn_mode_t          mode,
  input  logic [sn_geom_pkg::SN_W-1:0]   win_mask,
  output logic                           set_v,
  output logic [sn_geom_pkg::NUM_SN-1:0] set_vec,
  output logic [sn_geom_pkg::SLT_W-1:0]  set_slt,
  output logic                           pipe_busy
);

  logic                          cmp_acc;
  logic                          p1_v;
  logic [sn_geom_pkg::SN_W-1:0]  p1_sn;
  logic [sn_geom_pkg::SLT_W-1:0] p1_slt;
  logic [sn_geom_pkg::SN_W-1:0]  p1_offset;  // distance from slot head
  logic [sn_geom_pkg::SN_W-1:0]  p1_pos;     // bit index in the state vector

  // the advance cycle owns the pipe slot
  assign cmp_ready = ~advance;
  assign cmp_acc   = cmp_v & cmp_ready;

  //----------------------------------------------------------------------
  // p1: number and slot, head lookup
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p1_v <= 1'b0;
    end else begin
      p1_v <= cmp_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (cmp_acc) begin
      p1_sn  <= cmp_sn;
      p1_slt <= cmp_slt;
    end
  end

  assign rd_slt = p1_slt;

  always_comb begin
    p1_offset = (p1_sn - rd_shift) & win_mask;  // upper bits of cmp_sn drop out here
    if (advance && (advance_slt == p1_slt)) begin
      // head moves at the end of this cycle
      p1_offset = (p1_offset - 1'b1) & win_mask;
    end
    p1_pos = (sn_geom_pkg::SN_W'(p1_slt) << sn_mode_pkg::WIN_LOG2[mode]) + p1_offset;
  end

  //----------------------------------------------------------------------
  // p2: decoded bit, presented to the state window
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      set_v <= 1'b0;
    end else begin
      set_v <= p1_v;
    end
  end

  always_ff @(posedge clk) begin
    if (p1_v) begin
      set_vec <= sn_geom_pkg::NUM_SN'(1) << p1_pos;
      set_slt <= p1_slt;  // window uses it for the same-slot advance case
    end
  end

  assign pipe_busy = cmp_v | p1_v | set_v;  // includes a completion on the way in

  // completions only for slots that exist under the configured mode
  assert property (@(posedge clk) disable iff (!rst_n)
    cmp_v |-> ((int'(cmp_slt) << sn_mode_pkg::WIN_LOG2[mode]) < sn_geom_pkg::NUM_SN))
    else $error("completion for slot %0d outside mode %0d", cmp_slt, mode);

endmodule

/* verilog/sn_geom_pkg.sv */
// group geometry constants for the ordering RTL, referenced as sn_geom_pkg::name
package sn_geom_pkg;

  //----------------------------------------------------------------------
  // sequence number space of one group
  //----------------------------------------------------------------------

  localparam int NUM_SN = 512;  // numbers per group, also state vector width
  localparam int SN_W   = 9;    // log2 of NUM_SN

  //----------------------------------------------------------------------
  // slot space
  //----------------------------------------------------------------------

  // the densest mode splits the group into this many slots
  localparam int NUM_SLT = 8;
  localparam int SLT_W   = 3;   // slot index width

  // a slot's window always starts at slot times window size,
  // so the base needs no table of its own

endpackage

/* verilog/sn_mode_cfg.sv */
// mode register for the ordering block; takes a new sn_mode only while idle and gives the window mask
`timescale 1ns/1ns

module sn_mode_cfg (
  input  logic                         clk,
  input  logic                         rst_n,
  input  sn_mode_pkg::sn_mode_t        sn_mode,
  input  logic                         pipe_busy,
  input  logic                         window_empty,
  output sn_mode_pkg::sn_mode_t        mode,
  output logic [sn_geom_pkg::SN_W-1:0] win_mask
);

  logic idle;

  // nothing in the pipe and no completed number waiting for replay
  assign idle = ~pipe_busy & window_empty;

  //----------------------------------------------------------------------
  // mode register
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode <= sn_mode_pkg::SN_QID_64;
    end else if (idle) begin
      mode <= sn_mode;  // otherwise the old layout stays
    end
  end

  // window size minus one
  assign win_mask = sn_geom_pkg::SN_W'((1 << sn_mode_pkg::WIN_LOG2[mode]) - 1);

  //----------------------------------------------------------------------
  // coverage
  //----------------------------------------------------------------------

  // a new layout requested while work is still in flight, held off until idle
  cover property (@(posedge clk) disable iff (!rst_n)
    !idle && (sn_mode != mode));

endmodule

/* verilog/sn_mode_pkg.sv */
// mode encoding and per-mode window sizes, referenced as sn_mode_pkg::name
package sn_mode_pkg;

  //----------------------------------------------------------------------
  // configured slot layout
  //----------------------------------------------------------------------

  typedef enum logic [1:0] {
    SN_QID_64  = 2'd0,  // 8 slots, 64 numbers each
    SN_QID_128 = 2'd1,  // 4 slots, 128 numbers each
    SN_QID_256 = 2'd2,  // 2 slots, 256 numbers each
    SN_QID_512 = 2'd3   // whole group in one slot
  } sn_mode_t;

  //----------------------------------------------------------------------
  // window geometry
  //----------------------------------------------------------------------

  // log2 of the window size, indexed by sn_mode_t
  // window size times slot count is always the group size
  localparam int WIN_LOG2 [4] = '{6, 7, 8, 9};

  // slot base  = slot << WIN_LOG2[mode]
  // window mask = (1 << WIN_LOG2[mode]) - 1

endpackage

/* verilog/sn_order_top.sv */
// top of the sequence-number ordering block for one 512-number group; instantiate this one
`timescale 1ns/1ns

module sn_order_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cmp_v,
  input  logic [sn_geom_pkg::SN_W-1:0]  cmp_sn,
  input  logic [sn_geom_pkg::SLT_W-1:0] cmp_slt,
  output logic                          cmp_ready,
  output logic                          replay_v,
  input  logic                          replay_selected,
  output logic                          replay_sequence_v,
  output logic [sn_geom_pkg::SN_W-1:0]  replay_sequence,
  input  sn_mode_pkg::sn_mode_t         sn_mode,
  output logic                          dup_err
);

  //----------------------------------------------------------------------
  // internal nets, named as the block ports so they connect by name
  //----------------------------------------------------------------------

  sn_mode_pkg::sn_mode_t           mode;
  logic [sn_geom_pkg::SN_W-1:0]    win_mask;
  logic                            pipe_busy;
  logic                            window_empty;
  logic                            advance;
  logic [sn_geom_pkg::SLT_W-1:0]   advance_slt;
  logic [sn_geom_pkg::SLT_W-1:0]   rd_slt;
  logic [sn_geom_pkg::SN_W-1:0]    rd_shift;
  logic [sn_geom_pkg::SN_W-1:0]    shift_now;    // head of the slot being replayed
  logic                            set_v;
  logic [sn_geom_pkg::NUM_SN-1:0]  set_vec;
  logic [sn_geom_pkg::SLT_W-1:0]   set_slt;
  logic [sn_geom_pkg::NUM_SLT-1:0] oldest_req;

  //----------------------------------------------------------------------
  // blocks
  //----------------------------------------------------------------------

  sn_mode_cfg u_mode_cfg (.*);

  // second read port follows the slot being advanced
  sn_shift_table u_shift_table (
    .rd2_slt   (advance_slt),
    .rd2_shift (shift_now),
    .*
  );

  sn_cmp_pipe u_cmp_pipe (.*);

  sn_state_window u_state_window (.*);

  sn_replay_select u_replay_select (.*);

endmodule

/* verilog/sn_replay_select.sv */
// round-robin choice among slots with a completed oldest number; registers the pick, drives replay
`timescale 1ns/1ns

module sn_replay_select (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [sn_geom_pkg::NUM_SLT-1:0] oldest_req,
  input  logic                            replay_selected,
  input  sn_mode_pkg::sn_mode_t           mode,
  input  logic [sn_geom_pkg::SN_W-1:0]    shift_now,
  output logic                            replay_v,
  output logic                            advance,
  output logic [sn_geom_pkg::SLT_W-1:0]   advance_slt,
  output logic                            replay_sequence_v,
  output logic [sn_geom_pkg::SN_W-1:0]    replay_sequence
);

  logic                          win_v;
  logic [sn_geom_pkg::SLT_W-1:0] win_slt;
  logic [sn_geom_pkg::SLT_W-1:0] idx;
  logic                          take;
  logic                          sel_q;     // registered strobe, the advance cycle
  logic [sn_geom_pkg::SLT_W-1:0] last_slt;  // last winner, also the slot being advanced

  //----------------------------------------------------------------------
  // round robin, search starts one past the last winner
  //----------------------------------------------------------------------

  always_comb begin
    win_v   = 1'b0;
    win_slt = last_slt;
    idx     = last_slt;
    for (int i = 1; i <= sn_geom_pkg::NUM_SLT; i++) begin
      idx = last_slt + sn_geom_pkg::SLT_W'(i);  // wraps around the slot range
      if (!win_v && oldest_req[idx]) begin
        win_v   = 1'b1;
        win_slt = idx;
      end
    end
  end

  // no new offer while a pick waits for its advance
  assign replay_v = win_v & ~sel_q;
  assign take     = replay_selected & replay_v;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q    <= 1'b0;
      last_slt <= sn_geom_pkg::SLT_W'(sn_geom_pkg::NUM_SLT - 1);  // slot 0 wins first
    end else begin
      sel_q <= take;
      if (take) begin
        last_slt <= win_slt;
      end
    end
  end

  //----------------------------------------------------------------------
  // advance cycle outputs
  //----------------------------------------------------------------------

  assign advance           = sel_q;
  assign advance_slt       = last_slt;
  assign replay_sequence_v = sel_q;
  // slot base plus head before its increment
  assign replay_sequence   =
    (sn_geom_pkg::SN_W'(last_slt) << sn_mode_pkg::WIN_LOG2[mode]) + shift_now;

  assert property (@(posedge clk) disable iff (!rst_n)
    replay_selected |-> replay_v)
    else $error("replay_selected without replay_v");

endmodule

/* verilog/sn_shift_table.sv */
// per-slot head (shift) registers with two combinational reads and a wrapping increment on advance
`timescale 1ns/1ns

module sn_shift_table (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [sn_geom_pkg::SLT_W-1:0] rd_slt,
  output logic [sn_geom_pkg::SN_W-1:0]  rd_shift,
  input  logic [sn_geom_pkg::SLT_W-1:0] rd2_slt,
  output logic [sn_geom_pkg::SN_W-1:0]  rd2_shift,
  input  logic                          advance,
  input  logic [sn_geom_pkg::SLT_W-1:0] advance_slt,
  input  logic [sn_geom_pkg::SN_W-1:0]  win_mask
);

  // head of each slot's window, i.e. the next number to replay
  logic [sn_geom_pkg::SN_W-1:0] head [sn_geom_pkg::NUM_SLT];

  //----------------------------------------------------------------------
  // increment at the edge that ends the advance cycle
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < sn_geom_pkg::NUM_SLT; i++) begin
        head[i] <= '0;
      end
    end else if (advance) begin
      head[advance_slt] <= (head[advance_slt] + 1'b1) & win_mask;  // wraps at window size
    end
  end

  //----------------------------------------------------------------------
  // reads
  //----------------------------------------------------------------------

  // masked on the way out as well, so a head left from a wider mode
  // still lands inside the current window
  assign rd_shift  = head[rd_slt] & win_mask;   // completion pipe, p1
  assign rd2_shift = head[rd2_slt] & win_mask;  // replay number

endmodule

/* verilog/sn_state_window.sv */
// 512-bit completion state; window shift on advance, duplicate check and oldest-bit requests
`timescale 1ns/1ns

module sn_state_window (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            set_v,
  input  logic [sn_geom_pkg::NUM_SN-1:0]  set_vec,
  input  logic [sn_geom_pkg::SLT_W-1:0]   set_slt,
  input  logic                            advance,
  input  logic [sn_geom_pkg::SLT_W-1:0]   advance_slt,
  input  sn_mode_pkg::sn_mode_t           mode,
  output logic [sn_geom_pkg::NUM_SLT-1:0] oldest_req,
  output logic                            window_empty,
  output logic                            dup_err
);

  logic [sn_geom_pkg::NUM_SN-1:0] state_q;
  logic [sn_geom_pkg::NUM_SN-1:0] state_nxt;
  logic [sn_geom_pkg::NUM_SN-1:0] win_bits;  // advancing slot's window
  logic [sn_geom_pkg::NUM_SN-1:0] shifted;
  logic [sn_geom_pkg::NUM_SN-1:0] set_eff;
  int                             win_log2;
  int                             adv_base;
  int                             slt_base;

  //----------------------------------------------------------------------
  // next state
  //----------------------------------------------------------------------

  always_comb begin
    win_log2 = sn_mode_pkg::WIN_LOG2[mode];
    adv_base = int'(advance_slt) << win_log2;
    win_bits = ({sn_geom_pkg::NUM_SN{1'b1}} >> (sn_geom_pkg::NUM_SN - (1 << win_log2)))
               << adv_base;
    shifted  = state_q;
    set_eff  = set_vec;
    if (advance) begin
      // drop the oldest bit and fill the top of the window with zero
      shifted = (state_q & ~win_bits) | (((state_q & win_bits) >> 1) & win_bits);
      if (set_slt == advance_slt) begin
        set_eff = (set_vec >> 1) & win_bits;  // same frame as the shifted window
      end
    end
    state_nxt = set_v ? (shifted | set_eff) : shifted;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
      dup_err <= 1'b0;
    end else begin
      state_q <= state_nxt;
      // checked in the unshifted frame so a hit on the number being replayed counts too
      dup_err <= set_v & (|(state_q & set_vec));
    end
  end

  //----------------------------------------------------------------------
  // requests and idle
  //----------------------------------------------------------------------

  always_comb begin
    oldest_req = '0;
    slt_base   = 0;
    for (int i = 0; i < sn_geom_pkg::NUM_SLT; i++) begin
      slt_base = i << win_log2;
      if (slt_base < sn_geom_pkg::NUM_SN) begin  // slots beyond the mode stay quiet
        oldest_req[i] = state_q[slt_base];
      end
    end
  end

  assign window_empty = ~|state_q;

  // the decode in the completion pipe hands over a single bit
  assert property (@(posedge clk) disable iff (!rst_n)
    set_v |-> $onehot(set_vec))
    else $error("set_vec not one-hot: %h", set_vec);

endmodule
